//--- common/csr_pkg.sv
`default_nettype none

package csr_pkg;

  // widths
  localparam int CSR_XLEN     = 64;
  localparam int CSR_ADDR_W   = 12;
  localparam int COMMIT_CNT_W = 3;
  localparam int CAUSE_W      = 4;

  typedef logic [CSR_ADDR_W-1:0] csr_addr_t;
  typedef logic [CSR_XLEN-1:0]   csr_data_t;

  // register map
  localparam csr_addr_t ADDR_FFLAGS   = 12'h001;
  localparam csr_addr_t ADDR_FRM      = 12'h002;
  localparam csr_addr_t ADDR_SUP0     = 12'h500;
  localparam csr_addr_t ADDR_EPC      = 12'h502;
  localparam csr_addr_t ADDR_BADVADDR = 12'h503;
  localparam csr_addr_t ADDR_COUNT    = 12'h506;
  localparam csr_addr_t ADDR_EVEC     = 12'h508;
  localparam csr_addr_t ADDR_CAUSE    = 12'h509;
  localparam csr_addr_t ADDR_STATUS   = 12'h50a;

  // status bit positions
  localparam int SR_S     = 0;
  localparam int SR_PS    = 1;
  localparam int SR_EI    = 2;
  localparam int SR_PEI   = 3;
  localparam int SR_EF    = 4;
  localparam int SR_U64   = 5;
  localparam int SR_S64   = 6;
  localparam int SR_IM_LO = 16;
  localparam int SR_IM_HI = 23;

  // supervisor mode with both 64-bit modes enabled
  localparam csr_data_t STATUS_RESET = (csr_data_t'(1) << SR_S)
                                     | (csr_data_t'(1) << SR_U64)
                                     | (csr_data_t'(1) << SR_S64);

  localparam csr_data_t STATUS_WMASK = (csr_data_t'(1) << SR_S)
                                     | (csr_data_t'(1) << SR_PS)
                                     | (csr_data_t'(1) << SR_EI)
                                     | (csr_data_t'(1) << SR_PEI)
                                     | (csr_data_t'(1) << SR_EF)
                                     | (csr_data_t'(1) << SR_U64)
                                     | (csr_data_t'(1) << SR_S64)
                                     | ((csr_data_t'(1) << (SR_IM_HI + 1))
                                        - (csr_data_t'(1) << SR_IM_LO));

  localparam csr_data_t FFLAGS_MASK = csr_data_t'(64'h1f);
  localparam csr_data_t FRM_MASK    = csr_data_t'(64'h7);

  // exception causes that report a bad address
  localparam logic [CAUSE_W-1:0] CAUSE_MISALIGNED_FETCH = 4'd0;
  localparam logic [CAUSE_W-1:0] CAUSE_FAULT_FETCH      = 4'd1;
  localparam logic [CAUSE_W-1:0] CAUSE_MISALIGNED_LOAD  = 4'd4;
  localparam logic [CAUSE_W-1:0] CAUSE_FAULT_LOAD       = 4'd5;
  localparam logic [CAUSE_W-1:0] CAUSE_MISALIGNED_STORE = 4'd6;
  localparam logic [CAUSE_W-1:0] CAUSE_FAULT_STORE      = 4'd7;

  // one CSR write as issued by the CSR instruction
  typedef struct packed {
    csr_addr_t addr;
    csr_data_t data;
  } csr_wr_t;

  // exception report from the retire stage
  typedef struct packed {
    logic               valid;
    logic [CAUSE_W-1:0] cause;
    csr_data_t          pc;
    csr_data_t          ld_addr;
    csr_data_t          st_addr;
  } csr_excp_t;

endpackage

`default_nettype wire

//--- design/csr_commit_stage.sv
`timescale 1ns/10ps
`default_nettype none

module csr_commit_stage
(
  input  wire logic             clk,
  input  wire logic             reset,
  input  wire logic             flush_i,
  input  wire logic             commit_i,
  input  wire logic             wr_en_i,
  input  wire csr_pkg::csr_wr_t wr_i,
  output logic                  apply_o,
  output csr_pkg::csr_wr_t      apply_wr_o
);

  import csr_pkg::*;

  csr_wr_t pend_wr;
  logic    pend_valid;

  // payload of the staged write
  always_ff @(posedge clk)
  begin
    if (wr_en_i)
    begin
      pend_wr <= wr_i;
    end
  end

  // a new write wins over commit or flush in the same cycle
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      pend_valid <= 1'b0;
    end
    else if (wr_en_i)
    begin
      pend_valid <= 1'b1;
    end
    else if (commit_i || flush_i)
    begin
      pend_valid <= 1'b0;
    end
  end

  // a squashed CSR instruction leaves no trace in the registers
  assign apply_o    = commit_i & pend_valid;
  assign apply_wr_o = pend_wr;

endmodule

`default_nettype wire

//--- design/csr_regs.sv
`timescale 1ns/10ps
`default_nettype none

module csr_regs
(
  input  wire logic                               clk,
  input  wire logic                               reset,
  input  wire logic                               apply_i,
  input  wire csr_pkg::csr_wr_t                   apply_wr_i,
  input  wire csr_pkg::csr_excp_t                 excp_i,
  input  wire logic [csr_pkg::COMMIT_CNT_W-1:0]   retire_cnt_i,
  input  wire csr_pkg::csr_data_t                 fflags_i,
  input  wire logic                               sret_i,
  input  wire csr_pkg::csr_addr_t                 rd_addr_i,
  input  wire csr_pkg::csr_addr_t                 chk_addr_i,
  output csr_pkg::csr_data_t                      rd_data_o,
  output csr_pkg::csr_data_t                      chk_data_o,
  output csr_pkg::csr_data_t                      status_o,
  output csr_pkg::csr_data_t                      epc_o,
  output csr_pkg::csr_data_t                      evec_o,
  output csr_pkg::csr_data_t                      frm_o
);

  import csr_pkg::*;

  csr_data_t fflags_q;
  csr_data_t frm_q;
  csr_data_t sup0_q;
  csr_data_t epc_q;
  csr_data_t badvaddr_q;
  csr_data_t count_q;
  csr_data_t evec_q;
  csr_data_t cause_q;
  csr_data_t status_q;

  logic wr_fflags, wr_frm, wr_sup0, wr_epc, wr_badvaddr;
  logic wr_count, wr_evec, wr_cause, wr_status;

  csr_data_t badvaddr_next;
  csr_data_t status_next;
  csr_data_t wdata;

  assign wdata = apply_wr_i.data;

  // write strobes for the committed CSR instruction
  always_comb
  begin
    wr_fflags   = 1'b0;
    wr_frm      = 1'b0;
    wr_sup0     = 1'b0;
    wr_epc      = 1'b0;
    wr_badvaddr = 1'b0;
    wr_count    = 1'b0;
    wr_evec     = 1'b0;
    wr_cause    = 1'b0;
    wr_status   = 1'b0;
    if (apply_i)
    begin
      case (apply_wr_i.addr)
        ADDR_FFLAGS:   wr_fflags   = 1'b1;
        ADDR_FRM:      wr_frm      = 1'b1;
        ADDR_SUP0:     wr_sup0     = 1'b1;
        ADDR_EPC:      wr_epc      = 1'b1;
        ADDR_BADVADDR: wr_badvaddr = 1'b1;
        ADDR_COUNT:    wr_count    = 1'b1;
        ADDR_EVEC:     wr_evec     = 1'b1;
        ADDR_CAUSE:    wr_cause    = 1'b1;
        ADDR_STATUS:   wr_status   = 1'b1;
        default:       ;
      endcase
    end
  end

  // bad address source depends on where the fault came from
  always_comb
  begin
    badvaddr_next = badvaddr_q;
    if (excp_i.valid)
    begin
      case (excp_i.cause)
        CAUSE_MISALIGNED_FETCH, CAUSE_FAULT_FETCH: badvaddr_next = excp_i.pc;
        CAUSE_MISALIGNED_LOAD, CAUSE_FAULT_LOAD:   badvaddr_next = excp_i.ld_addr;
        CAUSE_MISALIGNED_STORE, CAUSE_FAULT_STORE: badvaddr_next = excp_i.st_addr;
        default:                                   badvaddr_next = badvaddr_q;
      endcase
    end
  end

  // sret restores privilege and interrupt enable from the saved copies
  always_comb
  begin
    status_next = status_q;
    if (sret_i)
    begin
      status_next[SR_S]  = status_q[SR_PS];
      status_next[SR_EI] = status_q[SR_PEI];
    end
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      fflags_q   <= '0;
      frm_q      <= '0;
      sup0_q     <= '0;
      epc_q      <= '0;
      badvaddr_q <= '0;
      count_q    <= '0;
      evec_q     <= '0;
      cause_q    <= '0;
      status_q   <= STATUS_RESET;
    end
    else
    begin
      fflags_q   <= wr_fflags ? (wdata & FFLAGS_MASK) : (fflags_q | (fflags_i & FFLAGS_MASK));
      frm_q      <= wr_frm ? (wdata & FRM_MASK) : frm_q;
      sup0_q     <= wr_sup0 ? wdata : sup0_q;
      epc_q      <= wr_epc ? wdata : (excp_i.valid ? excp_i.pc : epc_q);
      badvaddr_q <= wr_badvaddr ? wdata : badvaddr_next;
      // an exception counts as one retired instruction
      count_q    <= wr_count ? wdata
                             : count_q + csr_data_t'(retire_cnt_i)
                               + csr_data_t'(excp_i.valid);
      evec_q     <= wr_evec ? wdata : evec_q;
      cause_q    <= wr_cause ? wdata
                             : (excp_i.valid ? csr_data_t'(excp_i.cause) : cause_q);
      status_q   <= wr_status ? ((wdata & STATUS_WMASK) | (status_q & ~STATUS_WMASK))
                              : status_next;
    end
  end

  function automatic csr_data_t read_csr(input csr_addr_t addr);
    csr_data_t data;
    case (addr)
      ADDR_FFLAGS:   data = fflags_q;
      ADDR_FRM:      data = frm_q;
      ADDR_SUP0:     data = sup0_q;
      ADDR_EPC:      data = epc_q;
      ADDR_BADVADDR: data = badvaddr_q;
      ADDR_COUNT:    data = count_q;
      ADDR_EVEC:     data = evec_q;
      ADDR_CAUSE:    data = cause_q;
      ADDR_STATUS:   data = status_q;
      default:       data = '0;
    endcase
    return data;
  endfunction

  // instruction read port and checkpoint compare port
  always_comb
  begin
    rd_data_o  = read_csr(rd_addr_i);
    chk_data_o = read_csr(chk_addr_i);
  end

  assign status_o = status_q;
  assign epc_o    = epc_q;
  assign evec_o   = evec_q;
  assign frm_o    = frm_q;

endmodule

`default_nettype wire

//--- design/csr_atomic_check.sv
`timescale 1ns/10ps
`default_nettype none

module csr_atomic_check
(
  input  wire logic               clk,
  input  wire logic               reset,
  input  wire logic               flush_i,
  input  wire logic               commit_i,
  input  wire logic               rd_en_i,
  input  wire csr_pkg::csr_addr_t rd_addr_i,
  input  wire csr_pkg::csr_data_t rd_data_i,
  input  wire csr_pkg::csr_data_t chk_data_i,
  output csr_pkg::csr_addr_t      chk_addr_o,
  output logic                    violation_o
);

  import csr_pkg::*;

  csr_addr_t chk_addr;
  csr_data_t chk_data;
  logic      chk_valid;

  // address and value the CSR instruction saw
  always_ff @(posedge clk)
  begin
    if (rd_en_i)
    begin
      chk_addr <= rd_addr_i;
      chk_data <= rd_data_i;
    end
  end

  // the checkpoint lives until the instruction commits or is squashed
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      chk_valid <= 1'b0;
    end
    else if (rd_en_i)
    begin
      chk_valid <= 1'b1;
    end
    else if (flush_i || commit_i)
    begin
      chk_valid <= 1'b0;
    end
  end

  assign chk_addr_o = chk_addr;

  // retire re-executes the CSR instruction when this is set
  assign violation_o = chk_valid & (chk_data != chk_data_i);

endmodule

`default_nettype wire

//--- design/csr_unit.sv
`timescale 1ns/10ps
`default_nettype none

module csr_unit
(
  input  wire logic                             clk,
  input  wire logic                             reset,
  input  wire logic                             flush_i,
  input  wire logic                             wr_en_i,
  input  wire logic                             commit_i,
  input  wire logic                             rd_en_i,
  input  wire logic                             sret_i,
  input  wire csr_pkg::csr_wr_t                 wr_i,
  input  wire csr_pkg::csr_addr_t               rd_addr_i,
  input  wire csr_pkg::csr_excp_t               excp_i,
  input  wire logic [csr_pkg::COMMIT_CNT_W-1:0] retire_cnt_i,
  input  wire csr_pkg::csr_data_t               fflags_i,
  output csr_pkg::csr_data_t                    rd_data_o,
  output csr_pkg::csr_data_t                    status_o,
  output csr_pkg::csr_data_t                    epc_o,
  output csr_pkg::csr_data_t                    evec_o,
  output csr_pkg::csr_data_t                    frm_o,
  output logic                                  violation_o
);

  import csr_pkg::*;

  logic      apply;
  csr_wr_t   apply_wr;
  csr_addr_t chk_addr;
  csr_data_t chk_data;

  csr_commit_stage u_commit_stage (
    .clk        (clk),
    .reset      (reset),
    .flush_i    (flush_i),
    .commit_i   (commit_i),
    .wr_en_i    (wr_en_i),
    .wr_i       (wr_i),
    .apply_o    (apply),
    .apply_wr_o (apply_wr)
  );

  csr_regs u_regs (
    .clk          (clk),
    .reset        (reset),
    .apply_i      (apply),
    .apply_wr_i   (apply_wr),
    .excp_i       (excp_i),
    .retire_cnt_i (retire_cnt_i),
    .fflags_i     (fflags_i),
    .sret_i       (sret_i),
    .rd_addr_i    (rd_addr_i),
    .chk_addr_i   (chk_addr),
    .rd_data_o    (rd_data_o),
    .chk_data_o   (chk_data),
    .status_o     (status_o),
    .epc_o        (epc_o),
    .evec_o       (evec_o),
    .frm_o        (frm_o)
  );

  // checkpoint samples the same read data returned to the instruction
  csr_atomic_check u_atomic_check (
    .clk         (clk),
    .reset       (reset),
    .flush_i     (flush_i),
    .commit_i    (commit_i),
    .rd_en_i     (rd_en_i),
    .rd_addr_i   (rd_addr_i),
    .rd_data_i   (rd_data_o),
    .chk_data_i  (chk_data),
    .chk_addr_o  (chk_addr),
    .violation_o (violation_o)
  );

endmodule

`default_nettype wire

//--- tb/tb_csr_unit.sv
`timescale 1ns/10ps
`default_nettype none

module tb_csr_unit;

  import csr_pkg::*;

  // the tests need about 170 cycles
  localparam int MAX_CYCLES = 400;
  // status bits 0 to 6 and the interrupt mask 16 to 23
  localparam csr_data_t WMASK_STATUS = 64'h0000_0000_00ff_007f;
  localparam csr_data_t STATUS_AT_RESET = 64'h61;

  logic                    clk;
  logic                    reset;
  logic                    flush_i;
  logic                    wr_en_i;
  logic                    commit_i;
  logic                    rd_en_i;
  logic                    sret_i;
  csr_wr_t                 wr_i;
  csr_addr_t               rd_addr_i;
  csr_excp_t               excp_i;
  logic [COMMIT_CNT_W-1:0] retire_cnt_i;
  csr_data_t               fflags_i;
  csr_data_t               rd_data_o;
  csr_data_t               status_o;
  csr_data_t               epc_o;
  csr_data_t               evec_o;
  csr_data_t               frm_o;
  logic                    violation_o;

  int          errors;
  int          test_errors;
  int          tests_run;
  int          tests_failed;
  int          cycle_cnt;
  string       cur_test;

  csr_unit UUT (
    .clk          (clk),
    .reset        (reset),
    .flush_i      (flush_i),
    .wr_en_i      (wr_en_i),
    .commit_i     (commit_i),
    .rd_en_i      (rd_en_i),
    .sret_i       (sret_i),
    .wr_i         (wr_i),
    .rd_addr_i    (rd_addr_i),
    .excp_i       (excp_i),
    .retire_cnt_i (retire_cnt_i),
    .fflags_i     (fflags_i),
    .rd_data_o    (rd_data_o),
    .status_o     (status_o),
    .epc_o        (epc_o),
    .evec_o       (evec_o),
    .frm_o        (frm_o),
    .violation_o  (violation_o)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES)
    begin
      $display("timeout: run stopped after %0d cycles without finishing", cycle_cnt);
      $display("sim failed");
      $finish;
    end
  end

  task automatic check_value(input string what, input csr_data_t exp, input csr_data_t act);
    assert (act === exp)
    else
    begin
      $display("mismatch %s %s expected %h actual %h", cur_test, what, exp, act);
      errors++;
      test_errors++;
    end
  endtask

  // outputs settle well before the low phase ends
  task automatic read_expect(input string what, input csr_addr_t addr, input csr_data_t exp);
    rd_addr_i = addr;
    #1;
    check_value(what, exp, rd_data_o);
  endtask

  // one clock edge, then the strobes drop
  task automatic advance();
    @(negedge clk);
    wr_en_i      = 1'b0;
    commit_i     = 1'b0;
    flush_i      = 1'b0;
    rd_en_i      = 1'b0;
    sret_i       = 1'b0;
    excp_i.valid = 1'b0;
    retire_cnt_i = '0;
    fflags_i     = '0;
  endtask

  task automatic write_csr(input csr_addr_t addr, input csr_data_t data);
    wr_en_i = 1'b1;
    wr_i    = '{addr: addr, data: data};
    advance();
    commit_i = 1'b1;
    advance();
  endtask

  task automatic start_test(input string name);
    cur_test    = name;
    test_errors = 0;
  endtask

  task automatic finish_test();
    tests_run++;
    if (test_errors == 0)
    begin
      $display("test %s ok", cur_test);
    end
    else
    begin
      tests_failed++;
      $display("test %s failed with %0d errors", cur_test, test_errors);
    end
  endtask

  task automatic reset_state();
    csr_addr_t addrs [10];
    csr_data_t exp;
    addrs = '{ADDR_FFLAGS, ADDR_FRM, ADDR_SUP0, ADDR_EPC, ADDR_BADVADDR,
              ADDR_COUNT, ADDR_EVEC, ADDR_CAUSE, ADDR_STATUS, 12'h7ff};
    start_test("reset_state");
    check_value("status_o", STATUS_AT_RESET, status_o);
    check_value("violation_o", '0, csr_data_t'(violation_o));
    for (int i = 0; i < 10; i++)
    begin
      exp = (addrs[i] == ADDR_STATUS) ? STATUS_AT_RESET : '0;
      read_expect($sformatf("addr %h", addrs[i]), addrs[i], exp);
      advance();
    end
    finish_test();
  endtask

  task automatic staged_write();
    csr_data_t d_sup0;
    csr_data_t d_evec;
    csr_data_t d_status;
    csr_data_t d_frm;
    start_test("staged_write");
    d_sup0 = {$urandom, $urandom};
    wr_en_i = 1'b1;
    wr_i    = '{addr: ADDR_SUP0, data: d_sup0};
    advance();
    read_expect("sup0 while pending", ADDR_SUP0, '0);
    advance();
    commit_i = 1'b1;
    read_expect("sup0 at commit", ADDR_SUP0, '0);
    advance();
    read_expect("sup0 after commit", ADDR_SUP0, d_sup0);
    d_evec = {$urandom, $urandom};
    wr_en_i = 1'b1;
    wr_i    = '{addr: ADDR_EVEC, data: d_evec};
    advance();
    commit_i = 1'b1;
    read_expect("evec at commit", ADDR_EVEC, '0);
    advance();
    read_expect("evec after commit", ADDR_EVEC, d_evec);
    check_value("evec_o", d_evec, evec_o);
    // a squashed write must not reach sup0 on a later commit
    wr_en_i = 1'b1;
    wr_i    = '{addr: ADDR_SUP0, data: ~d_sup0};
    advance();
    flush_i = 1'b1;
    advance();
    commit_i = 1'b1;
    advance();
    read_expect("sup0 after flush", ADDR_SUP0, d_sup0);
    d_status = {$urandom, $urandom};
    write_csr(ADDR_STATUS, d_status);
    read_expect("status masked", ADDR_STATUS,
                (d_status & WMASK_STATUS) | (STATUS_AT_RESET & ~WMASK_STATUS));
    check_value("status_o", (d_status & WMASK_STATUS) | (STATUS_AT_RESET & ~WMASK_STATUS),
                status_o);
    d_frm = {$urandom, $urandom};
    write_csr(ADDR_FRM, d_frm);
    read_expect("frm masked", ADDR_FRM, d_frm & 64'h7);
    check_value("frm_o", d_frm & 64'h7, frm_o);
    finish_test();
  endtask

  task automatic exception_capture();
    logic [CAUSE_W-1:0] causes [9];
    csr_data_t          pc;
    csr_data_t          ld;
    csr_data_t          st;
    csr_data_t          exp_bad;
    // six listed causes, then three that leave badvaddr alone
    causes = '{4'd0, 4'd1, 4'd4, 4'd5, 4'd6, 4'd7, 4'd2, 4'd3, 4'd12};
    start_test("exception_capture");
    exp_bad = '0;
    for (int i = 0; i < 9; i++)
    begin
      pc = {$urandom, $urandom};
      ld = {$urandom, $urandom};
      st = {$urandom, $urandom};
      excp_i = '{valid: 1'b1, cause: causes[i], pc: pc, ld_addr: ld, st_addr: st};
      advance();
      case (causes[i])
        4'd0, 4'd1: exp_bad = pc;
        4'd4, 4'd5: exp_bad = ld;
        4'd6, 4'd7: exp_bad = st;
        default:    ;
      endcase
      read_expect("epc", ADDR_EPC, pc);
      read_expect("cause", ADDR_CAUSE, csr_data_t'(causes[i]));
      read_expect("badvaddr", ADDR_BADVADDR, exp_bad);
      check_value("epc_o", pc, epc_o);
    end
    finish_test();
  endtask

  task automatic counter_and_flags();
    csr_data_t               exp_count;
    csr_data_t               exp_fflags;
    csr_data_t               f;
    logic [COMMIT_CNT_W-1:0] r;
    logic                    v;
    start_test("counter_and_flags");
    write_csr(ADDR_FFLAGS, '0);
    write_csr(ADDR_COUNT, '0);
    exp_count  = '0;
    exp_fflags = '0;
    read_expect("count cleared", ADDR_COUNT, exp_count);
    for (int i = 0; i < 120; i++)
    begin
      r = 3'($urandom_range(0, 4));
      v = ($urandom_range(0, 3) == 0);
      // one flag bit per cycle somewhere in the word
      f = csr_data_t'(64'd1) << $urandom_range(0, 63);
      retire_cnt_i = r;
      excp_i       = '{valid: v, cause: 4'd9, pc: f, ld_addr: '0, st_addr: '0};
      fflags_i     = f;
      advance();
      exp_count  = exp_count + csr_data_t'(r) + csr_data_t'(v);
      exp_fflags = exp_fflags | (f & 64'h1f);
      read_expect("count", ADDR_COUNT, exp_count);
      read_expect("fflags", ADDR_FFLAGS, exp_fflags);
    end
    finish_test();
  endtask

  task automatic atomicity();
    csr_data_t v1;
    start_test("atomicity");
    v1 = {$urandom, $urandom};
    write_csr(ADDR_SUP0, v1);
    rd_en_i   = 1'b1;
    rd_addr_i = ADDR_SUP0;
    advance();
    check_value("violation after plain read", '0, csr_data_t'(violation_o));
    wr_en_i = 1'b1;
    wr_i    = '{addr: ADDR_SUP0, data: ~v1};
    advance();
    // the read is checkpointed at the same edge that applies the write
    rd_en_i   = 1'b1;
    rd_addr_i = ADDR_SUP0;
    commit_i  = 1'b1;
    advance();
    check_value("violation after sup0 write", 64'd1, csr_data_t'(violation_o));
    flush_i = 1'b1;
    advance();
    check_value("violation after flush", '0, csr_data_t'(violation_o));
    wr_en_i = 1'b1;
    wr_i    = '{addr: ADDR_EVEC, data: v1};
    advance();
    rd_en_i   = 1'b1;
    rd_addr_i = ADDR_SUP0;
    commit_i  = 1'b1;
    advance();
    check_value("violation after evec write", '0, csr_data_t'(violation_o));
    read_expect("evec", ADDR_EVEC, v1);
    flush_i = 1'b1;
    advance();
    finish_test();
  endtask

  task automatic sret_return();
    csr_data_t st;
    // PS and PEI set, S and EI clear, both 64-bit modes, mask 0xa5
    st = 64'h0000_0000_00a5_006a;
    start_test("sret");
    write_csr(ADDR_STATUS, st);
    read_expect("status before sret", ADDR_STATUS, st);
    sret_i = 1'b1;
    advance();
    read_expect("status after sret", ADDR_STATUS, st | 64'h5);
    check_value("status_o after sret", st | 64'h5, status_o);
    finish_test();
  endtask

  initial
  begin
    void'($urandom(62876));
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    cycle_cnt    = 0;
    reset        = 1'b1;
    flush_i      = 1'b0;
    wr_en_i      = 1'b0;
    commit_i     = 1'b0;
    rd_en_i      = 1'b0;
    sret_i       = 1'b0;
    wr_i         = '0;
    rd_addr_i    = '0;
    excp_i       = '0;
    retire_cnt_i = '0;
    fflags_i     = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    reset_state();
    staged_write();
    exception_capture();
    counter_and_flags();
    atomicity();
    sret_return();
    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0)
    begin
      $display("sim passed");
    end
    else
    begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
common/csr_pkg.sv
design/csr_commit_stage.sv
design/csr_regs.sv
design/csr_atomic_check.sv
design/csr_unit.sv
tb/tb_csr_unit.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module tb_csr_unit -f tb.f -o sim_csr_unit

./obj_dir/sim_csr_unit > sim.log 2>&1
cat sim.log

if grep -q "sim failed" sim.log
then
  exit 1
fi
exit 0
